// ==== hw/ilk_mgmt_pkg.sv ====
/*
 * Interlaken RX PCS management package
 * lane count, register map, status bit layout and shared vector types
 */
package ilk_mgmt_pkg;

   // ####################
   // lane geometry
   localparam int num_lanes  = 4;
   localparam int lane_sel_w = $clog2(num_lanes) + 1;  // one spare bit, out-of-range values exist
   localparam int sync_depth = 2;                      // flops per status synchronizer
   localparam int status_w   = 6;

   // ####################
   // plain vector types
   typedef logic [7:0]            mgmt_addr_t;    // word address
   typedef logic [31:0]           mgmt_data_t;
   typedef logic [num_lanes-1:0]  lane_vec_t;     // one bit per lane
   typedef logic [lane_sel_w-1:0] lane_sel_t;
   typedef logic [status_w-1:0]   lane_status_t;

   // read wait-state generator
   typedef enum logic {
      rd_idle,
      rd_wait
   } rd_state_t;

   // ####################
   // PCS register map, word addresses
   localparam mgmt_addr_t addr_lane_sel = 8'h80;  // indirect lane select
   localparam mgmt_addr_t addr_live     = 8'h81;  // synchronized status
   localparam mgmt_addr_t addr_sticky   = 8'h82;  // latched errors, write ones to clear

   // below 0x80 is the PMA space, reads as zero here
   localparam int pcs_space_bit = 7;

   // status word layout
   localparam int bit_align_val      = 0;
   localparam int bit_frame_lock     = 1;
   localparam int bit_framing_err    = 2;
   localparam int bit_crc32_err      = 3;
   localparam int bit_scram_mismatch = 4;
   localparam int bit_missing_sync   = 5;

   // error bits only, the two lock bits never latch
   localparam lane_status_t err_mask = lane_status_t'(
      (1 << bit_framing_err) |
      (1 << bit_crc32_err) |
      (1 << bit_scram_mismatch) |
      (1 << bit_missing_sync));

endpackage

// ==== hw/ilk_mgmt_decode.sv ====
/*
 * Management bus decoder
 * holds the indirect lane select and steers writes to one lane
 */
`timescale 1ns/1ps

module ilk_mgmt_decode
   import ilk_mgmt_pkg::*;
(
   input  logic       mgmt_clk,
   input  logic       rst,
   input  mgmt_addr_t mgmt_address,
   input  logic       mgmt_write,
   input  mgmt_data_t mgmt_datain,
   output lane_vec_t  lane_en,
   output lane_vec_t  sticky_clr_we
);

   lane_sel_t lane_sel;
   logic      sel_we;
   logic      clr_hit;

   // ####################
   // address match
   assign sel_we  = mgmt_write && (mgmt_address == addr_lane_sel);
   assign clr_hit = mgmt_write && (mgmt_address == addr_sticky);

   // ####################
   // indirect lane select register
   always_ff @(posedge mgmt_clk) begin
      if (rst) begin
         lane_sel <= '0;
      end else if (sel_we) begin
         lane_sel <= mgmt_datain[lane_sel_w-1:0];  // upper data bits ignored
      end
   end

   // one-hot decode
   // a value past the last lane selects nothing at all
   always_comb begin
      lane_en = '0;
      for (int i = 0; i < num_lanes; i++) begin
         if (lane_sel == lane_sel_t'(i)) begin
            lane_en[i] = 1'b1;
         end
      end
   end

   // clear strobe reaches the selected lane only
   assign sticky_clr_we = clr_hit ? lane_en : '0;

   // ####################
   // checks
   // no two lane slaves may drive the readback at once
   lane_en_onehot : assert property (
      @(posedge mgmt_clk) disable iff (rst)
      $onehot0(lane_en)
   ) else $error("lane_en has more than one lane selected");

endmodule

// ==== hw/ilk_lane_regs.sv ====
/*
 * Per-lane management registers
 * status synchronizers, sticky error flags and the lane read mux
 */
`timescale 1ns/1ps

module ilk_lane_regs
   import ilk_mgmt_pkg::*;
(
   input  logic         mgmt_clk,
   input  logic         rst,
   input  lane_status_t status_raw,     // asynchronous, from the lane clock domain
   input  mgmt_addr_t   mgmt_address,
   input  logic         sticky_clr_we,
   input  mgmt_data_t   mgmt_datain,
   output mgmt_data_t   lane_rdata
);

   lane_status_t sync_q [sync_depth];  // stage 0 takes the raw input
   lane_status_t live;
   lane_status_t sticky;
   lane_status_t clr_mask;
   lane_status_t err_seen;

   // ####################
   // two-flop synchronizer, all six bits in parallel
   always_ff @(posedge mgmt_clk) begin
      if (rst) begin
         for (int i = 0; i < sync_depth; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= status_raw;
         for (int i = 1; i < sync_depth; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign live = sync_q[sync_depth-1];

   // ####################
   // sticky error flags

   // lock bits are masked off both ways
   assign err_seen = live & err_mask;
   assign clr_mask = sticky_clr_we ? (mgmt_datain[status_w-1:0] & err_mask) : '0;

   // a live error beats a clear in the same cycle
   always_ff @(posedge mgmt_clk) begin
      if (rst) begin
         sticky <= '0;
      end else begin
         sticky <= (sticky & ~clr_mask) | err_seen;
      end
   end

   // ####################
   // register read mux
   // the readback block gates this word with the lane select
   always_comb begin
      case (mgmt_address)
         addr_live:   lane_rdata = mgmt_data_t'(live);
         addr_sticky: lane_rdata = mgmt_data_t'(sticky);
         default:     lane_rdata = '0;  // lane select and unmapped words
      endcase
   end

   // ####################
   // checks
   sticky_err_only : assert property (
      @(posedge mgmt_clk) disable iff (rst)
      (sticky & ~err_mask) == '0
   ) else $error("sticky flag set outside the error bits");

endmodule

// ==== hw/ilk_mgmt_readback.sv ====
/*
 * Management readback and wait-state generator
 * merges the selected lane word and holds off each read by one cycle
 */
`timescale 1ns/1ps

module ilk_mgmt_readback
   import ilk_mgmt_pkg::*;
(
   input  logic       mgmt_clk,
   input  logic       rst,
   input  mgmt_addr_t mgmt_address,
   input  logic       mgmt_read,
   input  lane_vec_t  lane_en,
   input  mgmt_data_t lane_rdata [num_lanes],
   output mgmt_data_t mgmt_dataout,
   output logic       mgmt_waitrequest
);

   rd_state_t  rd_state;
   mgmt_data_t pcs_rdata;
   mgmt_data_t rd_data;

   // ####################
   // gated OR over the lanes
   // at most one lane is enabled, so the OR is a plain mux
   always_comb begin
      pcs_rdata = '0;
      for (int i = 0; i < num_lanes; i++) begin
         if (lane_en[i]) begin
            pcs_rdata = pcs_rdata | lane_rdata[i];
         end
      end
   end

   // PMA space is gone, it reads as zero
   assign rd_data = mgmt_address[pcs_space_bit] ? pcs_rdata : '0;

   // ####################
   // read wait state
   // first read cycle stalls while the data is registered,
   // second cycle returns it
   always_ff @(posedge mgmt_clk) begin
      if (rst) begin
         rd_state     <= rd_idle;
         mgmt_dataout <= '0;
      end else begin
         case (rd_state)
            rd_idle: begin
               if (mgmt_read) begin
                  rd_state     <= rd_wait;
                  mgmt_dataout <= rd_data;  // address is held by the master
               end
            end
            rd_wait: begin
               rd_state <= rd_idle;  // read completes on this edge
            end
            default: begin
               rd_state <= rd_idle;
            end
         endcase
      end
   end

   // writes never stall
   assign mgmt_waitrequest = mgmt_read && (rd_state == rd_idle);

   // ####################
   // checks
   one_wait_cycle : assert property (
      @(posedge mgmt_clk) disable iff (rst)
      mgmt_waitrequest |=> !mgmt_waitrequest
   ) else $error("waitrequest held for two cycles");

endmodule

// ==== hw/ilk_mgmt_top.sv ====
/*
 * Interlaken RX PCS management top level
 * bus decoder, one register block per lane and the readback path
 */
`timescale 1ns/1ps

module ilk_mgmt_top
   import ilk_mgmt_pkg::*;
(
   input  logic       mgmt_clk,
   input  logic       rst,
   input  mgmt_addr_t mgmt_address,
   input  logic       mgmt_write,
   input  logic       mgmt_read,
   input  mgmt_data_t mgmt_datain,
   output mgmt_data_t mgmt_dataout,
   output logic       mgmt_waitrequest,
   // lane status, asynchronous
   input  lane_vec_t  rx_align_val,
   input  lane_vec_t  rx_frame_lock,
   input  lane_vec_t  rx_framing_error,
   input  lane_vec_t  rx_crc32err,
   input  lane_vec_t  rx_scrambler_mismatch,
   input  lane_vec_t  rx_missing_sync
);

   lane_vec_t  lane_en;
   lane_vec_t  sticky_clr_we;
   mgmt_data_t lane_rdata [num_lanes];

   ilk_mgmt_decode i_decode (
      .mgmt_clk      (mgmt_clk),
      .rst           (rst),
      .mgmt_address  (mgmt_address),
      .mgmt_write    (mgmt_write),
      .mgmt_datain   (mgmt_datain),
      .lane_en       (lane_en),
      .sticky_clr_we (sticky_clr_we)
   );

   // ####################
   // lane register blocks
   for (genvar g = 0; g < num_lanes; g++) begin : g_lane
      lane_status_t status_raw;

      // regroup the per-signal vectors into one status word per lane
      assign status_raw[bit_align_val]      = rx_align_val[g];
      assign status_raw[bit_frame_lock]     = rx_frame_lock[g];
      assign status_raw[bit_framing_err]    = rx_framing_error[g];
      assign status_raw[bit_crc32_err]      = rx_crc32err[g];
      assign status_raw[bit_scram_mismatch] = rx_scrambler_mismatch[g];
      assign status_raw[bit_missing_sync]   = rx_missing_sync[g];

      ilk_lane_regs i_lane_regs (
         .mgmt_clk      (mgmt_clk),
         .rst           (rst),
         .status_raw    (status_raw),
         .mgmt_address  (mgmt_address),
         .sticky_clr_we (sticky_clr_we[g]),
         .mgmt_datain   (mgmt_datain),
         .lane_rdata    (lane_rdata[g])
      );
   end

   ilk_mgmt_readback i_readback (
      .mgmt_clk         (mgmt_clk),
      .rst              (rst),
      .mgmt_address     (mgmt_address),
      .mgmt_read        (mgmt_read),
      .lane_en          (lane_en),
      .lane_rdata       (lane_rdata),
      .mgmt_dataout     (mgmt_dataout),
      .mgmt_waitrequest (mgmt_waitrequest)
   );

endmodule

// ==== tests/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * 4 ns mgmt_clk, rst held high for the first four rising edges
 */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic mgmt_clk,
   output logic rst
);

   localparam int half_period_ns = 2;
   localparam int rst_cycles     = 4;

   initial begin
      mgmt_clk = 1'b0;
      forever #(half_period_ns) mgmt_clk = ~mgmt_clk;
   end

   initial begin
      rst = 1'b1;
      repeat (rst_cycles) @(posedge mgmt_clk);
      rst <= 1'b0;  // released on the edge
   end

endmodule

// ==== tests/ilk_mgmt_tb.sv ====
/*
 * Testbench for the Interlaken RX PCS management block
 * random status and bus traffic checked against a register model
 */
`timescale 1ns/1ps

module ilk_mgmt_tb
   import ilk_mgmt_pkg::*;
();

   localparam int settle_cycles  = 6;   // status hold time before a read
   localparam int rd_timeout     = 8;
   localparam int rst_timeout    = 20;
   localparam int n_random_reads = 24;

   logic       mgmt_clk;
   logic       rst;
   mgmt_addr_t mgmt_address;
   logic       mgmt_write;
   logic       mgmt_read;
   mgmt_data_t mgmt_datain;
   mgmt_data_t mgmt_dataout;
   logic       mgmt_waitrequest;
   lane_vec_t  rx_align_val;
   lane_vec_t  rx_frame_lock;
   lane_vec_t  rx_framing_error;
   lane_vec_t  rx_crc32err;
   lane_vec_t  rx_scrambler_mismatch;
   lane_vec_t  rx_missing_sync;

   // register model
   int           model_sel;
   lane_status_t drv_status [num_lanes];    // what the lanes drive right now
   lane_status_t model_sticky [num_lanes];

   string test_name;
   int    check_count;
   int    err_count;
   int    timeout_count;

   tb_clk_gen i_clk_gen (
      .mgmt_clk (mgmt_clk),
      .rst      (rst)
   );

   ilk_mgmt_top i_dut (
      .mgmt_clk              (mgmt_clk),
      .rst                   (rst),
      .mgmt_address          (mgmt_address),
      .mgmt_write            (mgmt_write),
      .mgmt_read             (mgmt_read),
      .mgmt_datain           (mgmt_datain),
      .mgmt_dataout          (mgmt_dataout),
      .mgmt_waitrequest      (mgmt_waitrequest),
      .rx_align_val          (rx_align_val),
      .rx_frame_lock         (rx_frame_lock),
      .rx_framing_error      (rx_framing_error),
      .rx_crc32err           (rx_crc32err),
      .rx_scrambler_mismatch (rx_scrambler_mismatch),
      .rx_missing_sync       (rx_missing_sync)
   );

   // ####################
   // timing helpers
   task automatic next_cycle();
      @(posedge mgmt_clk);
      #1;  // drive point
   endtask

   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         next_cycle();
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      next_cycle();
      while (rst && cycles < rst_timeout) begin
         next_cycle();
         cycles++;
      end
      if (rst) begin
         $display("timeout: reset still asserted after %0d cycles", rst_timeout);
         timeout_count++;
      end
   endtask

   task automatic check_value(input string what, input mgmt_data_t expected,
                              input mgmt_data_t actual);
      check_count++;
      if (expected !== actual) begin
         $display("ERR %s %s: expected %h actual %h", test_name, what, expected, actual);
         err_count++;
      end
   endtask

   // ####################
   // model
   function automatic mgmt_data_t expected_read(input mgmt_addr_t addr);
      mgmt_data_t word;
      word = '0;
      if (addr[pcs_space_bit] && model_sel < num_lanes) begin
         if (addr == addr_live) begin
            word = mgmt_data_t'(drv_status[model_sel]);
         end else if (addr == addr_sticky) begin
            word = mgmt_data_t'(model_sticky[model_sel]);
         end
      end
      return word;
   endfunction

   task automatic model_write(input mgmt_addr_t addr, input mgmt_data_t data);
      lane_status_t clr;
      clr = data[status_w-1:0] & err_mask;
      if (addr == addr_lane_sel) begin
         model_sel = int'(data[lane_sel_w-1:0]);
      end else if (addr == addr_sticky && model_sel < num_lanes) begin
         // an error still present sets the flag again
         model_sticky[model_sel] = (model_sticky[model_sel] & ~clr) |
                                   (drv_status[model_sel] & err_mask);
      end
   endtask

   // drive the lanes from drv_status and let it settle
   task automatic apply_status();
      for (int l = 0; l < num_lanes; l++) begin
         rx_align_val[l]          = drv_status[l][bit_align_val];
         rx_frame_lock[l]         = drv_status[l][bit_frame_lock];
         rx_framing_error[l]      = drv_status[l][bit_framing_err];
         rx_crc32err[l]           = drv_status[l][bit_crc32_err];
         rx_scrambler_mismatch[l] = drv_status[l][bit_scram_mismatch];
         rx_missing_sync[l]       = drv_status[l][bit_missing_sync];
         model_sticky[l]          = model_sticky[l] | (drv_status[l] & err_mask);
      end
      wait_cycles(settle_cycles);
   endtask

   // random error pulse on every lane, then errors low again
   task automatic pulse_errors();
      for (int l = 0; l < num_lanes; l++) begin
         drv_status[l] = (drv_status[l] & ~err_mask) | (lane_status_t'($urandom) & err_mask);
      end
      apply_status();
      for (int l = 0; l < num_lanes; l++) begin
         drv_status[l] = drv_status[l] & ~err_mask;
      end
      apply_status();
   endtask

   // ####################
   // bus tasks
   task automatic write_reg(input mgmt_addr_t addr, input mgmt_data_t data);
      mgmt_address = addr;
      mgmt_datain  = data;
      mgmt_write   = 1'b1;
      next_cycle();  // write lands on this edge
      mgmt_write   = 1'b0;
      model_write(addr, data);
   endtask

   task automatic bus_read(input mgmt_addr_t addr, output mgmt_data_t data,
                           output int waits, output bit ok);
      int cycles;
      cycles       = 0;
      waits        = 0;
      ok           = 1'b0;
      data         = '0;
      mgmt_address = addr;
      mgmt_read    = 1'b1;
      while (!ok && cycles < rd_timeout) begin
         #2;  // sample mid cycle
         if (mgmt_waitrequest) begin
            waits++;
         end else begin
            data = mgmt_dataout;
            ok   = 1'b1;
         end
         next_cycle();
         cycles++;
      end
      mgmt_read = 1'b0;
      if (!ok) begin
         $display("timeout: read of address %h returned no data after %0d cycles",
                  addr, rd_timeout);
         timeout_count++;
      end
   endtask

   task automatic read_and_check(input mgmt_addr_t addr, input string what);
      mgmt_data_t data;
      int         waits;
      bit         ok;
      bus_read(addr, data, waits, ok);
      if (ok) begin
         check_value(what, expected_read(addr), data);
         check_value({what, " waits"}, mgmt_data_t'(1), mgmt_data_t'(waits));
      end
   endtask

   task automatic check_all_sticky(input string what);
      for (int l = 0; l < num_lanes; l++) begin
         write_reg(addr_lane_sel, mgmt_data_t'(l));
         read_and_check(addr_sticky, what);
      end
   endtask

   // ####################
   // test sequence
   initial begin
      mgmt_address          = '0;
      mgmt_write            = 1'b0;
      mgmt_read             = 1'b0;
      mgmt_datain           = '0;
      rx_align_val          = '0;
      rx_frame_lock         = '0;
      rx_framing_error      = '0;
      rx_crc32err           = '0;
      rx_scrambler_mismatch = '0;
      rx_missing_sync       = '0;
      model_sel     = 0;
      check_count   = 0;
      err_count     = 0;
      timeout_count = 0;
      for (int l = 0; l < num_lanes; l++) begin
         drv_status[l]   = '0;
         model_sticky[l] = '0;
      end
      void'($urandom(32'h7d901afa));
      wait_reset_release();

      test_name = "after_reset";
      check_all_sticky("sticky");
      for (int i = 0; i < 4; i++) begin
         read_and_check(mgmt_addr_t'($urandom_range(0, 127)), "pma read");
      end

      test_name = "live_status";
      for (int r = 0; r < 3; r++) begin
         for (int l = 0; l < num_lanes; l++) begin
            drv_status[l] = lane_status_t'($urandom);
         end
         apply_status();
         for (int l = 0; l < num_lanes; l++) begin
            write_reg(addr_lane_sel, mgmt_data_t'(l));
            read_and_check(addr_live, "live");
         end
      end

      test_name = "sticky_errors";
      for (int r = 0; r < 3; r++) begin
         pulse_errors();
      end
      for (int l = 0; l < num_lanes; l++) begin
         write_reg(addr_lane_sel, mgmt_data_t'(l));
         read_and_check(addr_sticky, "sticky");
         read_and_check(addr_live, "live");
      end

      test_name = "w1c";
      for (int r = 0; r < 4; r++) begin
         write_reg(addr_lane_sel, mgmt_data_t'($urandom_range(0, num_lanes - 1)));
         write_reg(addr_sticky, mgmt_data_t'($urandom));
         check_all_sticky("sticky after clear");
      end

      test_name = "out_of_range";
      pulse_errors();
      write_reg(addr_lane_sel, mgmt_data_t'($urandom_range(num_lanes, (1 << lane_sel_w) - 1)));
      read_and_check(addr_live, "live");
      read_and_check(addr_sticky, "sticky");
      write_reg(addr_sticky, '1);  // must hit no lane
      for (int i = 0; i < 4; i++) begin
         write_reg(mgmt_addr_t'($urandom_range(0, 127)), mgmt_data_t'($urandom));
      end
      read_and_check(addr_sticky, "sticky");
      check_all_sticky("sticky kept");
      read_and_check(mgmt_addr_t'($urandom_range(0, 127)), "pma read");

      test_name = "wait_state";
      for (int i = 0; i < n_random_reads; i++) begin
         if (i % 6 == 0) begin
            write_reg(addr_lane_sel, mgmt_data_t'($urandom_range(0, num_lanes)));
         end
         case ($urandom_range(0, 3))
            0: read_and_check(addr_live, "live");
            1: read_and_check(addr_sticky, "sticky");
            2: read_and_check(addr_lane_sel, "lane sel");
            default: read_and_check(mgmt_addr_t'($urandom_range(0, 127)), "pma read");
         endcase
      end

      $display("checks %0d, mismatches %0d, timeouts %0d",
               check_count, err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/ilk_mgmt_pkg.sv
hw/ilk_mgmt_decode.sv
hw/ilk_lane_regs.sv
hw/ilk_mgmt_readback.sv
hw/ilk_mgmt_top.sv
tests/tb_clk_gen.sv
tests/ilk_mgmt_tb.sv

// ==== Bender.yml ====
package:
  name: ilk_mgmt

sources:
  # RTL, package first
  - hw/ilk_mgmt_pkg.sv
  - hw/ilk_mgmt_decode.sv
  - hw/ilk_lane_regs.sv
  - hw/ilk_mgmt_readback.sv
  - hw/ilk_mgmt_top.sv

  # testbench
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/ilk_mgmt_tb.sv
